//--- source/tcore_pkg.sv
// tcore shared definitions
// opcode encoding, instruction field positions, fixed addresses and
// the micro-operation passed from decode to execute
package tcore_pkg;

  // data and address width, word addressed
  localparam int WORD_W = 16;

  // register file size and index width
  localparam int REG_N = 4;
  localparam int REG_W = 2;

  // instruction word fields
  localparam int OP_W   = 4;
  localparam int OP_LSB = 12;
  localparam int RD_LSB = 10;
  localparam int RS_LSB = 8;

  // first fetch after reset
  localparam logic [WORD_W-1:0] RESET_PC = 16'h0000;
  // interrupt handler entry
  localparam logic [WORD_W-1:0] IRQ_VECTOR = 16'h0040;

  typedef enum logic [OP_W-1:0] {
    OP_NOP  = 4'd0,
    OP_LDI  = 4'd1,
    OP_MOV  = 4'd2,
    OP_ADD  = 4'd3,
    OP_SUB  = 4'd4,
    OP_AND  = 4'd5,
    OP_XOR  = 4'd6,
    OP_LD   = 4'd7,
    OP_ST   = 4'd8,
    OP_JMP  = 4'd9,
    OP_JZ   = 4'd10,
    OP_IRET = 4'd11,
    OP_HALT = 4'd12
  } opcode_e;

  // fetch waits for an instruction word or its immediate
  typedef enum logic {
    FS_INSTR,
    FS_IMM
  } fetch_state_e;

  typedef struct packed {
    opcode_e           op;
    logic [REG_W-1:0]  rd;
    logic [REG_W-1:0]  rs;
    logic [WORD_W-1:0] imm;
    // address after this instruction, the return point
    logic [WORD_W-1:0] next_pc;
  } uop_t;

  // opcodes followed by one immediate word
  function automatic logic has_imm(logic [OP_W-1:0] op);
    return (op == OP_LDI) || (op == OP_JMP) || (op == OP_JZ);
  endfunction

endpackage

//--- source/tcore_if.sv
// tcore pipeline stage interfaces
// fetch to decode carries raw instruction words with their immediate,
// decode to execute carries micro-operations and the redirect back

interface tcore_fd_if;
  logic                         valid;
  logic                         ready;
  logic [tcore_pkg::WORD_W-1:0] instr;
  logic [tcore_pkg::WORD_W-1:0] imm;
  logic [tcore_pkg::WORD_W-1:0] next_pc;
  // drop the held item
  logic                         flush;

  modport fetch (output valid, instr, imm, next_pc, input ready, flush);
  modport decode (input valid, instr, imm, next_pc, output ready, flush);
endinterface

interface tcore_de_if;
  logic                         valid;
  logic                         ready;
  tcore_pkg::uop_t              uop;
  // taken jump or iret, one cycle
  logic                         redirect;
  logic [tcore_pkg::WORD_W-1:0] target;
  logic                         iret;

  modport decode (output valid, uop, input ready, redirect);
  modport exec (input valid, uop, output ready, redirect, target, iret);
endinterface

//--- source/tcore_fetch.sv
// tcore fetch unit
// keeps the program counter and reads instruction words from the shared
// bus while decode has room, pairing opcodes that carry an immediate with
// the following word. redirects from execute restart it at the new target.
// also enters the interrupt vector and holds the return address for iret
module tcore_fetch (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         grant_i,
  input  logic                         block_i,
  input  logic [tcore_pkg::WORD_W-1:0] rdata_i,
  input  logic                         intr_i,
  output logic [tcore_pkg::WORD_W-1:0] pc_o,
  output logic                         req_o,
  output logic                         inta_o,
  tcore_fd_if.fetch                    fd,
  input  logic                         redirect_i,
  input  logic [tcore_pkg::WORD_W-1:0] target_i,
  input  logic                         iret_i
);

  logic [tcore_pkg::WORD_W-1:0] pc_q;
  logic [tcore_pkg::WORD_W-1:0] ret_q;
  tcore_pkg::fetch_state_e      state_q;
  logic                         out_valid_q;
  logic [tcore_pkg::WORD_W-1:0] instr_q;
  logic [tcore_pkg::WORD_W-1:0] imm_q;
  logic [tcore_pkg::WORD_W-1:0] next_pc_q;
  logic                         active_q;
  logic                         inta_q;
  logic                         room;
  logic                         take_irq;
  logic                         done;
  logic                         pair;

  // output slot free now or emptied this cycle
  assign room = !out_valid_q || fd.ready;

  // interrupt only at an instruction boundary with nothing left behind
  // decode is empty or retires its item this cycle without a redirect
  assign take_irq = intr_i && !active_q && !out_valid_q &&
                    (state_q == tcore_pkg::FS_INSTR) && fd.ready && !redirect_i;

  // bus stays idle while in reset
  assign req_o = !reset_i && room && !redirect_i && !take_irq;
  // word read completes
  assign done  = req_o && grant_i && !block_i;
  // instruction word needs a second read
  assign pair  = tcore_pkg::has_imm(rdata_i[tcore_pkg::OP_LSB +: tcore_pkg::OP_W]);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q        <= tcore_pkg::RESET_PC;
      state_q     <= tcore_pkg::FS_INSTR;
      out_valid_q <= 1'b0;
      active_q    <= 1'b0;
      inta_q      <= 1'b0;
    end else begin
      // single cycle acknowledge
      inta_q <= take_irq;
      if (fd.valid && fd.ready) begin
        out_valid_q <= 1'b0;
      end
      // discard held and partial items
      if (fd.flush) begin
        out_valid_q <= 1'b0;
        state_q     <= tcore_pkg::FS_INSTR;
      end
      if (redirect_i) begin
        // iret goes back to the saved address
        pc_q <= iret_i ? ret_q : target_i;
        if (iret_i) begin
          active_q <= 1'b0;
        end
      end else if (take_irq) begin
        pc_q     <= tcore_pkg::IRQ_VECTOR;
        active_q <= 1'b1;
      end else if (done) begin
        pc_q <= pc_q + 1'b1;
        if (state_q == tcore_pkg::FS_IMM) begin
          state_q     <= tcore_pkg::FS_INSTR;
          out_valid_q <= 1'b1;
        end else if (pair) begin
          state_q <= tcore_pkg::FS_IMM;
        end else begin
          out_valid_q <= 1'b1;
        end
      end
    end
  end

  // item payload and return address
  always_ff @(posedge clk) begin
    if (take_irq) begin
      ret_q <= pc_q;
    end
    if (done) begin
      if (state_q == tcore_pkg::FS_INSTR) begin
        instr_q <= rdata_i;
        imm_q   <= '0;
      end else begin
        imm_q <= rdata_i;
      end
      next_pc_q <= pc_q + 1'b1;
    end
  end

  assign fd.valid   = out_valid_q;
  assign fd.instr   = instr_q;
  assign fd.imm     = imm_q;
  assign fd.next_pc = next_pc_q;
  assign pc_o       = pc_q;
  assign inta_o     = inta_q;

endmodule

//--- source/tcore_decode.sv
// tcore decode stage
// turns an instruction word and its immediate into a registered
// micro-operation. unknown opcodes decode as nop. a redirect from
// execute empties this stage and is passed on to fetch as flush
module tcore_decode (
  input  logic       clk,
  input  logic       reset_i,
  tcore_fd_if.decode fd,
  tcore_de_if.decode de
);

  logic                           valid_q;
  tcore_pkg::uop_t                uop_q;
  tcore_pkg::uop_t                uop_d;
  logic [tcore_pkg::OP_W-1:0]     op_field;

  assign op_field = fd.instr[tcore_pkg::OP_LSB +: tcore_pkg::OP_W];

  always_comb begin
    // encodings past halt are not defined
    if (op_field <= tcore_pkg::OP_HALT) begin
      uop_d.op = tcore_pkg::opcode_e'(op_field);
    end else begin
      uop_d.op = tcore_pkg::OP_NOP;
    end
    uop_d.rd      = fd.instr[tcore_pkg::RD_LSB +: tcore_pkg::REG_W];
    uop_d.rs      = fd.instr[tcore_pkg::RS_LSB +: tcore_pkg::REG_W];
    // immediate only meaningful for paired opcodes
    uop_d.imm     = tcore_pkg::has_imm(op_field) ? fd.imm : '0;
    uop_d.next_pc = fd.next_pc;
  end

  // room when empty or execute takes the current uop
  assign fd.ready = !valid_q || de.ready;
  // redirect also clears the fetch side
  assign fd.flush = de.redirect;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (de.redirect) begin
      // incoming item belongs to the wrong path
      valid_q <= 1'b0;
    end else if (fd.ready) begin
      valid_q <= fd.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fd.valid && fd.ready) begin
      uop_q <= uop_d;
    end
  end

  assign de.valid = valid_q;
  assign de.uop   = uop_q;

endmodule

//--- source/tcore_exec.sv
// tcore execution unit
// works directly on the uop held in decode and retires it when done.
// holds the four registers and the zero flag, runs the alu, makes the
// bus access for ld and st, resolves jumps and iret, and stops on halt
module tcore_exec (
  input  logic                         clk,
  input  logic                         reset_i,
  tcore_de_if.exec                     de,
  output logic                         req_o,
  output logic [tcore_pkg::WORD_W-1:0] adr_o,
  output logic                         we_o,
  output logic [tcore_pkg::WORD_W-1:0] wdata_o,
  output logic                         halted_o,
  input  logic                         block_i,
  input  logic [tcore_pkg::WORD_W-1:0] rdata_i
);

  tcore_pkg::uop_t              u;
  logic [tcore_pkg::WORD_W-1:0] regs [tcore_pkg::REG_N];
  logic [tcore_pkg::WORD_W-1:0] a;
  logic [tcore_pkg::WORD_W-1:0] b;
  logic [tcore_pkg::WORD_W-1:0] result;
  logic                         zf_q;
  logic                         halted_q;
  logic                         mem_op;
  logic                         accept;
  logic                         wr_rd;
  logic                         upd_zf;
  logic                         taken;

  assign u = de.uop;
  // rd is also the store data source
  assign a = regs[u.rd];
  // rs is also the load/store address
  assign b = regs[u.rs];

  assign mem_op  = de.valid && !halted_q &&
                   ((u.op == tcore_pkg::OP_LD) || (u.op == tcore_pkg::OP_ST));
  assign req_o   = mem_op;
  assign adr_o   = b;
  assign we_o    = mem_op && (u.op == tcore_pkg::OP_ST);
  assign wdata_o = a;

  // memory ops wait for their completing bus cycle
  assign de.ready = !halted_q && !(mem_op && block_i);
  assign accept   = de.valid && de.ready;

  always_comb begin
    result = b;
    wr_rd  = 1'b0;
    upd_zf = 1'b0;
    taken  = 1'b0;
    case (u.op)
      tcore_pkg::OP_LDI: begin
        result = u.imm;
        wr_rd  = 1'b1;
      end
      tcore_pkg::OP_MOV: begin
        result = b;
        wr_rd  = 1'b1;
      end
      tcore_pkg::OP_ADD: begin
        result = a + b;
        wr_rd  = 1'b1;
        upd_zf = 1'b1;
      end
      tcore_pkg::OP_SUB: begin
        result = a - b;
        wr_rd  = 1'b1;
        upd_zf = 1'b1;
      end
      tcore_pkg::OP_AND: begin
        result = a & b;
        wr_rd  = 1'b1;
        upd_zf = 1'b1;
      end
      tcore_pkg::OP_XOR: begin
        result = a ^ b;
        wr_rd  = 1'b1;
        upd_zf = 1'b1;
      end
      tcore_pkg::OP_LD: begin
        result = rdata_i;
        wr_rd  = 1'b1;
        upd_zf = 1'b1;
      end
      tcore_pkg::OP_JMP:  taken = 1'b1;
      tcore_pkg::OP_JZ:   taken = zf_q;
      tcore_pkg::OP_IRET: taken = 1'b1;
      default: ;
    endcase
  end

  // redirect only in the retiring cycle
  assign de.redirect = accept && taken;
  assign de.iret     = accept && (u.op == tcore_pkg::OP_IRET);
  // resolved next address, fall-through unless a jump is taken
  // fetch uses its saved address for iret
  assign de.target   = (taken && (u.op != tcore_pkg::OP_IRET)) ? u.imm : u.next_pc;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      zf_q     <= 1'b0;
      halted_q <= 1'b0;
    end else if (accept) begin
      if (upd_zf) begin
        zf_q <= (result == '0);
      end
      // stays until reset
      if (u.op == tcore_pkg::OP_HALT) begin
        halted_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept && wr_rd) begin
      regs[u.rd] <= result;
    end
  end

  assign halted_o = halted_q;

endmodule

//--- source/tcore_top.sv
// tcore processor top level
// fetch, decode and execute stages sharing one memory bus.
// execute has priority and its request selects the bus owner,
// except that a blocked fetch read keeps the bus until it completes
module tcore_top (
  input  logic                         clk,
  input  logic                         reset_i,
  input  logic                         intr_i,
  input  logic                         mem_block_i,
  input  logic [tcore_pkg::WORD_W-1:0] mem_dat_i,
  output logic                         inta_o,
  output logic [tcore_pkg::WORD_W-1:0] pc_o,
  output logic                         halted_o,
  output logic                         mem_req_o,
  output logic [tcore_pkg::WORD_W-1:0] mem_adr_o,
  output logic                         mem_we_o,
  output logic [tcore_pkg::WORD_W-1:0] mem_dat_o
);

  tcore_fd_if fd_if ();
  tcore_de_if de_if ();

  logic                         fetch_req;
  logic [tcore_pkg::WORD_W-1:0] fetch_pc;
  logic                         exec_req;
  logic [tcore_pkg::WORD_W-1:0] exec_adr;
  logic                         exec_we;
  logic [tcore_pkg::WORD_W-1:0] exec_wdata;
  logic                         exec_sel;
  logic                         lock_q;

  // fetch or exec select
  assign exec_sel = exec_req && !lock_q;

  // fetch read stalled on the bus, hold off execute
  always_ff @(posedge clk) begin
    if (reset_i) begin
      lock_q <= 1'b0;
    end else begin
      lock_q <= !exec_sel && fetch_req && mem_block_i;
    end
  end

  assign mem_req_o = exec_sel || fetch_req;
  assign mem_adr_o = exec_sel ? exec_adr : fetch_pc;
  assign mem_we_o  = exec_sel && exec_we;
  assign mem_dat_o = exec_wdata;
  assign pc_o      = fetch_pc;

  tcore_fetch u_fetch (
    .clk        (clk),
    .reset_i    (reset_i),
    .grant_i    (!exec_sel),
    .block_i    (mem_block_i),
    .rdata_i    (mem_dat_i),
    .intr_i     (intr_i),
    .pc_o       (fetch_pc),
    .req_o      (fetch_req),
    .inta_o     (inta_o),
    .fd         (fd_if.fetch),
    .redirect_i (de_if.redirect),
    .target_i   (de_if.target),
    .iret_i     (de_if.iret)
  );

  tcore_decode u_decode (
    .clk     (clk),
    .reset_i (reset_i),
    .fd      (fd_if.decode),
    .de      (de_if.decode)
  );

  // a locked-out request looks blocked to execute
  tcore_exec u_exec (
    .clk      (clk),
    .reset_i  (reset_i),
    .de       (de_if.exec),
    .req_o    (exec_req),
    .adr_o    (exec_adr),
    .we_o     (exec_we),
    .wdata_o  (exec_wdata),
    .halted_o (halted_o),
    .block_i  (mem_block_i || lock_q),
    .rdata_i  (mem_dat_i)
  );

endmodule

//--- verif/tcore_clkgen.sv
// tcore testbench clock and reset
// free running clock, reset held while restart is high
// and for 5 more cycles after it drops
module tcore_clkgen (
  input  logic restart_i,
  output logic clk_o,
  output logic reset_o
);

  logic [2:0] cnt = 3'd0;

  initial clk_o = 1'b0;
  // period 4
  always #2 clk_o = ~clk_o;

  always @(posedge clk_o) begin
    if (restart_i) begin
      cnt <= 3'd0;
    end else if (cnt < 3'd5) begin
      cnt <= cnt + 3'd1;
    end
  end

  assign reset_o = restart_i || (cnt < 3'd5);

endmodule

//--- verif/tcore_mem.sv
// tcore testbench memory model
// 256 words, combinational read, optional random wait states,
// loader port for programs and a record of completed stores
module tcore_mem (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        stall_en_i,
  input  logic        load_en_i,
  input  logic [7:0]  load_adr_i,
  input  logic [15:0] load_dat_i,
  input  logic        req_i,
  input  logic [15:0] adr_i,
  input  logic        we_i,
  input  logic [15:0] wdata_i,
  output logic [15:0] rdata_o,
  output logic        block_o
);

  logic [15:0] ram [256];
  logic [15:0] st_adr [64];
  logic [15:0] st_dat [64];
  int          st_cnt;
  integer      seed = 36;
  integer      rnd;
  logic        block_q = 1'b0;
  logic        store;

  assign rdata_o = ram[adr_i[7:0]];
  assign block_o = block_q;
  assign store   = req_i && we_i && !block_q;

  // wait states change just after the edge
  always @(posedge clk) begin
    #1;
    rnd = $random(seed);
    block_q <= stall_en_i ? rnd[0] : 1'b0;
  end

  always @(posedge clk) begin
    if (load_en_i) begin
      ram[load_adr_i] <= load_dat_i;
    end else if (store) begin
      ram[adr_i[7:0]] <= wdata_i;
    end
  end

  // store log, in completion order
  always @(posedge clk) begin
    if (reset_i) begin
      st_cnt <= 0;
    end else if (store) begin
      if (st_cnt < 64) begin
        st_adr[st_cnt[5:0]] <= adr_i;
        st_dat[st_cnt[5:0]] <= wdata_i;
      end
      st_cnt <= st_cnt + 1;
    end
  end

endmodule

//--- verif/tcore_chk.sv
// tcore bus and interrupt checks
// bound into the top level where it sees the execute bus select
module tcore_chk (
  input logic        clk,
  input logic        reset_i,
  input logic        exec_sel_i,
  input logic        block_i,
  input logic [15:0] adr_i,
  input logic        we_i,
  input logic [15:0] dat_i,
  input logic        inta_i
);

  // blocked load or store keeps the bus unchanged
  a_exec_hold: assert property (@(posedge clk) disable iff (reset_i)
    exec_sel_i && block_i |=> exec_sel_i && $stable(adr_i) && $stable(we_i) &&
    (!we_i || $stable(dat_i)))
    else $error("execute bus access changed while blocked");

  // acknowledge is a single pulse
  a_inta_pulse: assert property (@(posedge clk) disable iff (reset_i)
    inta_i |=> !inta_i)
    else $error("inta_o high for more than one cycle");

endmodule

bind tcore_top tcore_chk u_chk (
  .clk        (clk),
  .reset_i    (reset_i),
  .exec_sel_i (exec_sel),
  .block_i    (mem_block_i),
  .adr_i      (mem_adr_o),
  .we_i       (mem_we_o),
  .dat_i      (mem_dat_o),
  .inta_i     (inta_o)
);

//--- verif/tcore_tb.sv
// tcore testbench top
// directed programs for reset, alu, load/store with jz, wait states
// and interrupt entry/return, checked against the stores they make
module tcore_tb;

  localparam int CLK_PERIOD = 4;
  localparam int LOAD_CYC   = 270;
  localparam int B_RESET    = 200;
  localparam int B_ARITH    = 400;
  localparam int B_LDST     = 500;
  localparam int B_STALL    = 4000;
  localparam int B_IRQ      = 800;
  // six program loads plus every wait budget of every test
  localparam int WD_CYC = 6 * LOAD_CYC + 2 * B_RESET + B_ARITH + B_LDST +
                          2 * B_STALL + 3 * B_IRQ + 100;

  logic        clk;
  logic        reset;
  logic        restart;
  logic        intr;
  logic        stall_en;
  logic        load_en;
  logic [7:0]  load_adr;
  logic [15:0] load_dat;
  logic        mem_block;
  logic [15:0] mem_rdata;
  logic        inta;
  logic [15:0] pc_o;
  logic        halted;
  logic        mem_req;
  logic [15:0] mem_adr;
  logic        mem_we;
  logic [15:0] mem_wdata;

  logic [15:0] prog [256];
  logic [15:0] exp_adr [$];
  logic [15:0] exp_dat [$];
  int          cur;
  int          errors;
  int          test_errs;
  int          tests;
  int          inta_cnt;

  tcore_clkgen u_clkgen (
    .restart_i (restart),
    .clk_o     (clk),
    .reset_o   (reset)
  );

  tcore_mem u_mem (
    .clk        (clk),
    .reset_i    (reset),
    .stall_en_i (stall_en),
    .load_en_i  (load_en),
    .load_adr_i (load_adr),
    .load_dat_i (load_dat),
    .req_i      (mem_req),
    .adr_i      (mem_adr),
    .we_i       (mem_we),
    .wdata_i    (mem_wdata),
    .rdata_o    (mem_rdata),
    .block_o    (mem_block)
  );

  tcore_top DUT (
    .clk         (clk),
    .reset_i     (reset),
    .intr_i      (intr),
    .mem_block_i (mem_block),
    .mem_dat_i   (mem_rdata),
    .inta_o      (inta),
    .pc_o        (pc_o),
    .halted_o    (halted),
    .mem_req_o   (mem_req),
    .mem_adr_o   (mem_adr),
    .mem_we_o    (mem_we),
    .mem_dat_o   (mem_wdata)
  );

  // acknowledge pulses per run
  always @(posedge clk) begin
    if (reset) begin
      inta_cnt <= 0;
    end else if (inta) begin
      inta_cnt <= inta_cnt + 1;
    end
  end

  initial begin
    #(WD_CYC * CLK_PERIOD);
    $display("watchdog: simulation did not finish in time");
    $display("Finished with errors");
    $finish;
  end

  function automatic logic [15:0] ins(tcore_pkg::opcode_e op, logic [1:0] rd,
                                      logic [1:0] rs);
    return {op, rd, rs, 8'h00};
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic put(logic [15:0] w);
    prog[cur[7:0]] = w;
    cur = cur + 1;
  endtask

  task automatic op1(tcore_pkg::opcode_e op, logic [1:0] rd, logic [1:0] rs);
    put(ins(op, rd, rs));
  endtask

  // instruction followed by its immediate word
  task automatic op2(tcore_pkg::opcode_e op, logic [1:0] rd, logic [15:0] imm);
    put(ins(op, rd, 2'd0));
    put(imm);
  endtask

  task automatic new_program();
    for (int i = 0; i < 256; i++) begin
      prog[i] = 16'h0000;
    end
    cur = 0;
    exp_adr.delete();
    exp_dat.delete();
  endtask

  task automatic expect_store(logic [15:0] a, logic [15:0] d);
    exp_adr.push_back(a);
    exp_dat.push_back(d);
  endtask

  // load memory under reset and then let reset run out
  task automatic run_program(logic stall);
    restart  = 1'b1;
    stall_en = stall;
    tick();
    load_en = 1'b1;
    for (int i = 0; i < 256; i++) begin
      load_adr = i[7:0];
      load_dat = prog[i];
      tick();
    end
    load_en = 1'b0;
    restart = 1'b0;
    tick();
  endtask

  task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      $display("ERROR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      test_errs++;
    end
  endtask

  task automatic wait_halt(int budget);
    int n;
    n = 0;
    while (!halted && n < budget) begin
      tick();
      n++;
    end
    if (!halted) begin
      $display("program did not reach halt within %0d cycles", budget);
      test_errs++;
    end
  endtask

  task automatic check_stores();
    int n;
    n = u_mem.st_cnt;
    check_count("store count", n, exp_adr.size());
    if (n > exp_adr.size()) begin
      n = exp_adr.size();
    end
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("store[%0d] mem_adr_o", i), u_mem.st_adr[i[5:0]], exp_adr[i]);
      check_word($sformatf("store[%0d] mem_dat_o", i), u_mem.st_dat[i[5:0]], exp_dat[i]);
    end
  endtask

  task automatic finish_test(string name);
    tests++;
    errors += test_errs;
    if (test_errs == 0) begin
      $display("test %s: passed", name);
    end else begin
      $display("test %s: failed with %0d errors", name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic test_reset();
    int n;
    new_program();
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0080);
    op1(tcore_pkg::OP_ST, 2'd3, 2'd3);
    op1(tcore_pkg::OP_HALT, 2'd0, 2'd0);
    expect_store(16'h0080, 16'h0080);
    run_program(1'b0);
    while (reset) begin
      check_word("mem_req_o", {15'd0, mem_req}, 16'd0);
      check_word("mem_we_o", {15'd0, mem_we}, 16'd0);
      check_word("inta_o", {15'd0, inta}, 16'd0);
      check_word("halted_o", {15'd0, halted}, 16'd0);
      check_word("pc_o", pc_o, tcore_pkg::RESET_PC);
      tick();
    end
    n = 0;
    while (!mem_req && n < B_RESET) begin
      tick();
      n++;
    end
    if (!mem_req) begin
      $display("no memory request within %0d cycles after reset", B_RESET);
      test_errs++;
    end else begin
      check_word("mem_adr_o", mem_adr, 16'h0000);
    end
    wait_halt(B_RESET);
    check_stores();
    finish_test("reset");
  endtask

  task automatic build_arith();
    logic [15:0] r0;
    logic [15:0] r1;
    new_program();
    r0 = 16'h1234;
    r1 = 16'h0f0f;
    op2(tcore_pkg::OP_LDI, 2'd0, r0);
    op2(tcore_pkg::OP_LDI, 2'd1, r1);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0080);
    op1(tcore_pkg::OP_ADD, 2'd0, 2'd1);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    r0 = r0 + r1;
    expect_store(16'h0080, r0);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0081);
    op1(tcore_pkg::OP_SUB, 2'd0, 2'd1);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    r0 = r0 - r1;
    expect_store(16'h0081, r0);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0082);
    op1(tcore_pkg::OP_AND, 2'd0, 2'd1);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    r0 = r0 & r1;
    expect_store(16'h0082, r0);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0083);
    op1(tcore_pkg::OP_XOR, 2'd0, 2'd1);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    r0 = r0 ^ r1;
    expect_store(16'h0083, r0);
    // mov into r2 then store r2
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0084);
    op1(tcore_pkg::OP_MOV, 2'd2, 2'd0);
    op1(tcore_pkg::OP_ST, 2'd2, 2'd3);
    expect_store(16'h0084, r0);
    op1(tcore_pkg::OP_HALT, 2'd0, 2'd0);
  endtask

  task automatic build_ldst();
    int fix;
    new_program();
    op2(tcore_pkg::OP_LDI, 2'd0, 16'h00a5);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0090);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    op1(tcore_pkg::OP_LD, 2'd1, 2'd3);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0091);
    op1(tcore_pkg::OP_ST, 2'd1, 2'd3);
    expect_store(16'h0090, 16'h00a5);
    expect_store(16'h0091, 16'h00a5);
    // load of zero sets zf so jz is taken
    op2(tcore_pkg::OP_LDI, 2'd0, 16'h0000);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0092);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    op1(tcore_pkg::OP_LD, 2'd1, 2'd3);
    expect_store(16'h0092, 16'h0000);
    fix = cur;
    op2(tcore_pkg::OP_JZ, 2'd0, 16'h0000);
    op2(tcore_pkg::OP_LDI, 2'd2, 16'h00ee);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0093);
    op1(tcore_pkg::OP_ST, 2'd2, 2'd3);
    prog[fix + 1] = cur[15:0];
    op2(tcore_pkg::OP_LDI, 2'd2, 16'h0011);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0093);
    op1(tcore_pkg::OP_ST, 2'd2, 2'd3);
    expect_store(16'h0093, 16'h0011);
    // nonzero load clears zf so jz falls through
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0090);
    op1(tcore_pkg::OP_LD, 2'd1, 2'd3);
    fix = cur;
    op2(tcore_pkg::OP_JZ, 2'd0, 16'h0000);
    op2(tcore_pkg::OP_LDI, 2'd2, 16'h0022);
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0094);
    op1(tcore_pkg::OP_ST, 2'd2, 2'd3);
    expect_store(16'h0094, 16'h0022);
    prog[fix + 1] = cur[15:0];
    op1(tcore_pkg::OP_HALT, 2'd0, 2'd0);
  endtask

  task automatic test_program(string name, int which, logic stall, int budget);
    if (which == 0) begin
      build_arith();
    end else begin
      build_ldst();
    end
    run_program(stall);
    wait_halt(budget);
    check_stores();
    check_word("halted_o", {15'd0, halted}, 16'd1);
    finish_test(name);
  endtask

  task automatic test_irq();
    int loop;
    int fix;
    int n;
    new_program();
    op2(tcore_pkg::OP_LDI, 2'd1, 16'd8);
    op2(tcore_pkg::OP_LDI, 2'd2, 16'd1);
    op2(tcore_pkg::OP_LDI, 2'd0, 16'd0);
    loop = cur;
    op1(tcore_pkg::OP_ADD, 2'd0, 2'd2);
    op1(tcore_pkg::OP_SUB, 2'd1, 2'd2);
    fix = cur;
    op2(tcore_pkg::OP_JZ, 2'd0, 16'h0000);
    op2(tcore_pkg::OP_JMP, 2'd0, loop[15:0]);
    prog[fix + 1] = cur[15:0];
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0080);
    op1(tcore_pkg::OP_ST, 2'd0, 2'd3);
    op1(tcore_pkg::OP_HALT, 2'd0, 2'd0);
    // handler leaves r0..r2 and zf alone
    cur = tcore_pkg::IRQ_VECTOR;
    op2(tcore_pkg::OP_LDI, 2'd3, 16'h0090);
    op1(tcore_pkg::OP_ST, 2'd3, 2'd3);
    op1(tcore_pkg::OP_IRET, 2'd0, 2'd0);
    expect_store(16'h0090, 16'h0090);
    expect_store(16'h0080, 16'd8);
    run_program(1'b0);
    n = 0;
    while (!(mem_req && mem_adr == loop[15:0] + 16'd1) && n < B_IRQ) begin
      tick();
      n++;
    end
    intr = 1'b1;
    n = 0;
    while (inta_cnt == 0 && n < B_IRQ) begin
      tick();
      n++;
    end
    if (inta_cnt == 0) begin
      $display("interrupt was never acknowledged");
      test_errs++;
    end
    intr = 1'b0;
    wait_halt(B_IRQ);
    check_count("inta_o pulses", inta_cnt, 1);
    check_stores();
    finish_test("interrupt");
  endtask

  initial begin
    restart   = 1'b1;
    intr      = 1'b0;
    stall_en  = 1'b0;
    load_en   = 1'b0;
    load_adr  = 8'h00;
    load_dat  = 16'h0000;
    errors    = 0;
    test_errs = 0;
    tests     = 0;
    cur       = 0;
    test_reset();
    test_program("arith", 0, 1'b0, B_ARITH);
    test_program("load_store", 1, 1'b0, B_LDST);
    test_program("arith_stall", 0, 1'b1, B_STALL);
    test_program("load_store_stall", 1, 1'b1, B_STALL);
    test_irq();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- filelist.f
source/tcore_pkg.sv
source/tcore_if.sv
source/tcore_fetch.sv
source/tcore_decode.sv
source/tcore_exec.sv
source/tcore_top.sv
verif/tcore_clkgen.sv
verif/tcore_mem.sv
verif/tcore_chk.sv
verif/tcore_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tcore simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tcore_tb \
  -Mdir obj_dir -o tcore_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tcore_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" sim.log; then
  exit 1
fi

if ! grep -q "Finished with no errors" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
